// ==== stepper_ctrl_top.f ====
src/stepper_pkg.sv
src/spi_word.sv
src/spi_state_machine.sv
src/dda_timer.sv
src/stepper_ctrl_top.sv
dv/stepper_checker.sv
dv/tb_stepper_ctrl.sv

// ==== dv/tb_stepper_ctrl.sv ====
`timescale 1ns/1ps

module tb_stepper_ctrl import stepper_pkg::*; ();

  // SCK half period in CLK cycles
  localparam int HALF_SCK    = 5;
  localparam int NUM_MOVES   = 7;
  // Enable, motor config, divisor, two version words, four words per move
  localparam int NUM_WORDS   = 5 + 4 * NUM_MOVES;
  localparam int WORD_CYCLES = 16 + 64 * 2 * HALF_SCK;

  logic        CLK;
  logic        resetn;
  logic        SCK;
  logic        CS;
  logic        COPI;
  logic [63:0] encoder_count;
  logic        CIPO;
  logic        step;
  logic        dir;
  logic        enable;
  logic [2:0]  microsteps;
  logic [7:0]  current;
  logic        buffer_dtr;
  logic        move_done;

  // Moves 0 to 3 are random and move 4 is long with 5 and 6 behind it
  logic        dir_a    [NUM_MOVES];
  logic [63:0] dur_a    [NUM_MOVES];
  logic [63:0] inc_a    [NUM_MOVES];
  logic [63:0] incinc_a [NUM_MOVES];
  logic [7:0]  div;

  stepper_ctrl_top u_dut (
    .CLK           (CLK),
    .resetn        (resetn),
    .SCK           (SCK),
    .CS            (CS),
    .COPI          (COPI),
    .encoder_count (encoder_count),
    .CIPO          (CIPO),
    .step          (step),
    .dir           (dir),
    .enable        (enable),
    .microsteps    (microsteps),
    .current       (current),
    .buffer_dtr    (buffer_dtr),
    .move_done     (move_done)
  );

  stepper_checker u_checker (
    .CLK        (CLK),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .move_done  (move_done),
    .buffer_dtr (buffer_dtr),
    .enable     (enable),
    .microsteps (microsteps),
    .current    (current)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // One framed SPI word in mode 0 with reply bits taken just before rising SCK
  task automatic send_word(input logic [63:0] data, output logic [63:0] reply);
    int i;
    reply = '0;
    @(negedge CLK);
    CS = 1'b0;
    repeat (HALF_SCK) @(negedge CLK);
    for (i = 63; i >= 0; i--) begin
      COPI = data[i];
      repeat (HALF_SCK) @(negedge CLK);
      reply[i] = CIPO;
      SCK = 1'b1;
      repeat (HALF_SCK) @(negedge CLK);
      SCK = 1'b0;
    end
    repeat (HALF_SCK) @(negedge CLK);
    CS = 1'b1;
    // Gap lets the decoder load the next reply
    repeat (2 * HALF_SCK) @(negedge CLK);
  endtask

  // Header plus three data words with the snapshot checked on the last
  task automatic send_move(input int idx);
    cmd_word_u   hdr;
    logic [63:0] snap;
    logic [63:0] reply;
    while (!buffer_dtr) @(negedge CLK);
    u_checker.add_move(dir_a[idx], dur_a[idx], inc_a[idx], incinc_a[idx]);
    snap = {$urandom, $urandom};
    encoder_count = snap;
    hdr.raw = '0;
    hdr.move.cmd = CMD_COORDINATED_STEP;
    hdr.move.dir = dir_a[idx];
    send_word(hdr.raw, reply);
    // Encoder moves on but the reply must still hold the header value
    encoder_count = {$urandom, $urandom};
    send_word(dur_a[idx], reply);
    send_word(inc_a[idx], reply);
    send_word(incinc_a[idx], reply);
    u_checker.compare_value("encoder snapshot", reply, snap);
  endtask

  initial begin
    int              seed;
    int              i;
    longint unsigned total_ticks;
    longint unsigned timeout_ns;
    logic [63:0]     reply;
    cmd_word_u       hdr;
    logic [7:0]      cur;
    logic [2:0]      ms;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    encoder_count = '0;
    resetn = 1'b0;
    seed = 72843;
    void'($urandom(seed));

    for (i = 0; i < NUM_MOVES; i++) begin
      dir_a[i]    = 1'($urandom % 2);
      dur_a[i]    = 64'(4 + $urandom % 37);
      inc_a[i]    = 64'($urandom);
      incinc_a[i] = 64'($urandom % 65536);
    end
    // Long enough to outlast the next move's transfer
    dur_a[4] = 64'(2000 + $urandom % 200);
    div = 8'(1 + $urandom % 6);

    // Start and release ticks on top of each duration
    total_ticks = 0;
    for (i = 0; i < NUM_MOVES; i++) begin
      total_ticks = total_ticks + dur_a[i] + 2;
    end
    timeout_ns = total_ticks * (div + 1) * 20 + NUM_WORDS * WORD_CYCLES * 20 + 20000;
    fork
      begin
        #(timeout_ns);
        $display("timeout: run hung, moves not finished after %0d ns", timeout_ns);
        $display(">>> FAIL");
        $finish;
      end
    join_none

    repeat (5) @(negedge CLK);
    resetn = 1'b1;
    repeat (2) @(negedge CLK);
    u_checker.check_status(1'b0, 8'd140, 3'd2, 1'b1);

    hdr.raw = '0;
    hdr.enable.cmd = CMD_MOTOR_ENABLE;
    hdr.enable.en = 1'b1;
    send_word(hdr.raw, reply);
    u_checker.check_status(1'b1, 8'd140, 3'd2, 1'b1);

    cur = 8'($urandom);
    ms = 3'($urandom);
    hdr.raw = '0;
    hdr.motor_cfg.cmd = CMD_MOTORCONFIG;
    hdr.motor_cfg.current = cur;
    hdr.motor_cfg.microsteps = ms;
    send_word(hdr.raw, reply);
    u_checker.check_status(1'b1, cur, ms, 1'b1);

    hdr.raw = '0;
    hdr.divisor.cmd = CMD_CLK_DIVISOR;
    hdr.divisor.div = div;
    send_word(hdr.raw, reply);

    // Version comes back during the trailing word
    hdr.raw = '0;
    hdr.move.cmd = CMD_API_VERSION;
    send_word(hdr.raw, reply);
    send_word({$urandom, $urandom}, reply);
    u_checker.compare_value("api version", reply,
                            {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH});

    for (i = 0; i < 4; i++) begin
      send_move(i);
    end
    while (u_checker.done_count != 4) @(negedge CLK);

    // Both slots busy behind the long move
    send_move(4);
    send_move(5);
    u_checker.compare_value("buffer_dtr, both slots busy", {63'd0, buffer_dtr}, 64'd0);
    while (!buffer_dtr) @(negedge CLK);
    @(negedge CLK);
    u_checker.compare_value("moves done as slot frees", 64'(u_checker.done_count), 64'd5);
    send_move(6);
    while (u_checker.done_count != NUM_MOVES) @(negedge CLK);
    repeat (10) @(negedge CLK);
    u_checker.finish_moves();

    $display("checks %0d, errors %0d, moves done %0d",
             u_checker.checks, u_checker.errors, u_checker.done_count);
    if (u_checker.errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== dv/stepper_checker.sv ====
`timescale 1ns/1ps

module stepper_checker (
  input logic       CLK,
  input logic       resetn,
  input logic       step,
  input logic       dir,
  input logic       move_done,
  input logic       buffer_dtr,
  input logic       enable,
  input logic [2:0] microsteps,
  input logic [7:0] current
);

  int checks     = 0;
  int errors     = 0;
  int done_count = 0;

  logic [63:0] step_count = '0;
  // Accumulator carries across moves and starts at zero
  logic [63:0] model_acc  = '0;
  logic [63:0] exp_steps_q [$];
  logic        exp_dir_q   [$];

  // Step count in the upper half and final accumulator in the lower half
  function automatic logic [127:0] dda_model(input logic [63:0] acc_start,
                                             input logic [63:0] duration,
                                             input logic [63:0] inc_start,
                                             input logic [63:0] incinc);
    logic [63:0]     acc;
    logic [63:0]     inc;
    logic [63:0]     nxt;
    logic [63:0]     steps;
    longint unsigned t;
    acc = acc_start;
    inc = inc_start;
    steps = '0;
    for (t = 0; t < duration; t++) begin
      nxt = acc + inc;
      // A step each time the integer part changes
      if (nxt[63:32] != acc[63:32]) begin
        steps = steps + 64'd1;
      end
      acc = nxt;
      inc = inc + incinc;
    end
    return {steps, acc};
  endfunction

  task automatic compare_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input logic en, input logic [7:0] cur,
                              input logic [2:0] ms, input logic dtr);
    compare_value("enable", {63'd0, enable}, {63'd0, en});
    compare_value("current", {56'd0, current}, {56'd0, cur});
    compare_value("microsteps", {61'd0, microsteps}, {61'd0, ms});
    compare_value("buffer_dtr", {63'd0, buffer_dtr}, {63'd0, dtr});
  endtask

  // Expected results queued in the order the moves are sent
  task automatic add_move(input logic d, input logic [63:0] dur,
                          input logic [63:0] inc, input logic [63:0] incinc);
    logic [127:0] res;
    res = dda_model(model_acc, dur, inc, incinc);
    exp_steps_q.push_back(res[127:64]);
    exp_dir_q.push_back(d);
    model_acc = res[63:0];
  endtask

  task automatic finish_moves();
    if (exp_steps_q.size() != 0) begin
      errors++;
      $display("error at %0t: %0d queued moves never finished", $time, exp_steps_q.size());
    end
  endtask

  always @(posedge CLK) begin
    if (resetn) begin
      if (step) begin
        step_count = step_count + 64'd1;
        if (exp_dir_q.size() == 0) begin
          errors++;
          $display("error at %0t: step pulse with no move queued", $time);
        end else begin
          compare_value("dir during move", {63'd0, dir}, {63'd0, exp_dir_q[0]});
        end
      end
      // Close out the move at the head of the queue
      if (move_done) begin
        if (exp_steps_q.size() == 0) begin
          errors++;
          $display("error at %0t: move_done with no move queued", $time);
        end else begin
          compare_value($sformatf("steps of move %0d", done_count), step_count,
                        exp_steps_q.pop_front());
          void'(exp_dir_q.pop_front());
        end
        step_count = '0;
        done_count++;
      end
    end
  end

endmodule

// ==== src/stepper_ctrl_top.sv ====
`timescale 1ns/1ps

module stepper_ctrl_top import stepper_pkg::*; (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        SCK,
  input  logic        CS,
  input  logic        COPI,
  input  logic [63:0] encoder_count,
  output logic        CIPO,
  output logic        step,
  output logic        dir,
  output logic        enable,
  output logic [2:0]  microsteps,
  output logic [7:0]  current,
  output logic        buffer_dtr,
  output logic        move_done
);

  // SPI word interface
  logic [WORD_BITS-1:0] word_send_data;
  logic [WORD_BITS-1:0] word_data_received;
  logic                 word_received;

  // Decoder to timer, slot handshake and move words
  logic [MOVE_BUFFER_BITS-1:0] moveind;
  logic [MOVE_BUFFER_SIZE-1:0] stepready;
  logic [MOVE_BUFFER_SIZE-1:0] stepfinished;
  logic [7:0]                  clock_divisor;
  logic [63:0]                 move_duration;
  logic [63:0]                 increment;
  logic [63:0]                 incrementincrement;

  spi_word u_spi_word (
    .CLK                (CLK),
    .resetn             (resetn),
    .SCK                (SCK),
    .CS                 (CS),
    .COPI               (COPI),
    .word_send_data     (word_send_data),
    .CIPO               (CIPO),
    .word_received      (word_received),
    .word_data_received (word_data_received)
  );

  spi_state_machine u_spi_state_machine (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_received      (word_received),
    .word_data_received (word_data_received),
    .encoder_count      (encoder_count),
    .moveind            (moveind),
    .stepfinished       (stepfinished),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .microsteps         (microsteps),
    .current            (current),
    .clock_divisor      (clock_divisor),
    .stepready          (stepready),
    .dir                (dir),
    .buffer_dtr         (buffer_dtr),
    .move_duration      (move_duration),
    .increment          (increment),
    .incrementincrement (incrementincrement)
  );

  dda_timer u_dda_timer (
    .CLK                (CLK),
    .resetn             (resetn),
    .clock_divisor      (clock_divisor),
    .move_duration      (move_duration),
    .increment          (increment),
    .incrementincrement (incrementincrement),
    .stepready          (stepready),
    .stepfinished       (stepfinished),
    .moveind            (moveind),
    .step               (step),
    .move_done          (move_done)
  );

endmodule

// ==== src/dda_timer.sv ====
`timescale 1ns/1ps

module dda_timer import stepper_pkg::*; (
  input  logic                        CLK,
  input  logic                        resetn,
  input  logic [7:0]                  clock_divisor,
  input  logic [63:0]                 move_duration,
  input  logic [63:0]                 increment,
  input  logic [63:0]                 incrementincrement,
  input  logic [MOVE_BUFFER_SIZE-1:0] stepready,
  output logic [MOVE_BUFFER_SIZE-1:0] stepfinished,
  output logic [MOVE_BUFFER_BITS-1:0] moveind,
  output logic                        step,
  output logic                        move_done
);

  // Tick divider
  logic [7:0] tick_cnt;
  logic       tick;

  // Move state
  logic        running;
  logic        slot_busy;
  logic        move_end;
  logic [63:0] move_count;

  // Position accumulator, integer part in the upper half
  logic [63:0] accumulator;
  logic [63:0] acc_next;
  logic [63:0] increment_r;

  // Compare with >= so a lowered divisor takes effect at once
  assign tick = tick_cnt >= clock_divisor;

  // Toggle bits differ while the decoder has a move waiting
  assign slot_busy = stepready[moveind] != stepfinished[moveind];
  assign move_end  = move_count == move_duration;
  assign acc_next  = accumulator + increment_r;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tick_cnt     <= '0;
      running      <= 1'b0;
      stepfinished <= '0;
      moveind      <= '0;
      step         <= 1'b0;
      move_done    <= 1'b0;
      accumulator  <= '0;
      increment_r  <= '0;
      move_count   <= '0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;

      if (tick) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end

      if (tick) begin
        if (!running) begin
          // Start tick only loads the move
          if (slot_busy) begin
            running     <= 1'b1;
            increment_r <= increment;
            move_count  <= '0;
          end
        end else if (move_end) begin
          // Release the slot, accumulator is kept
          running               <= 1'b0;
          stepfinished[moveind] <= ~stepfinished[moveind];
          moveind               <= moveind + 1'b1;
          move_done             <= 1'b1;
        end else begin
          accumulator <= acc_next;
          // Increment ramps by incrementincrement after each add
          increment_r <= increment_r + incrementincrement;
          move_count  <= move_count + 64'd1;
          // Step whenever the integer part moves
          step        <= acc_next[63:32] != accumulator[63:32];
        end
      end
    end
  end

endmodule

// ==== src/spi_state_machine.sv ====
`timescale 1ns/1ps

module spi_state_machine import stepper_pkg::*; (
  input  logic                        CLK,
  input  logic                        resetn,
  input  logic                        word_received,
  input  logic [WORD_BITS-1:0]        word_data_received,
  input  logic [63:0]                 encoder_count,
  input  logic [MOVE_BUFFER_BITS-1:0] moveind,
  input  logic [MOVE_BUFFER_SIZE-1:0] stepfinished,
  output logic [WORD_BITS-1:0]        word_send_data,
  output logic                        enable,
  output logic [2:0]                  microsteps,
  output logic [7:0]                  current,
  output logic [7:0]                  clock_divisor,
  output logic [MOVE_BUFFER_SIZE-1:0] stepready,
  output logic                        dir,
  output logic                        buffer_dtr,
  output logic [63:0]                 move_duration,
  output logic [63:0]                 increment,
  output logic [63:0]                 incrementincrement
);

  cmd_word_u hdr;

  // Edge detect on the word pulse
  logic [1:0] word_received_r;
  logic       word_strobe;
  logic       header_strobe;
  logic       move_strobe;

  // Header of a multi-word message and position within it
  logic [7:0] message_header;
  logic [1:0] message_word_count;
  logic       awaiting_more_words;

  // Slot the next move goes into
  logic [MOVE_BUFFER_BITS-1:0] writemoveind;
  logic [MOVE_BUFFER_SIZE-1:0] dir_r;

  // Encoder value taken at the move header
  logic [63:0] encoder_store;

  // Move buffer
  logic [63:0] duration_buf  [MOVE_BUFFER_SIZE];
  logic [63:0] increment_buf [MOVE_BUFFER_SIZE];
  logic [63:0] incinc_buf    [MOVE_BUFFER_SIZE];

  assign hdr.raw     = word_data_received;
  assign word_strobe = word_received_r == 2'b01;

  // Move and version commands take a following word
  assign awaiting_more_words = (message_header == CMD_COORDINATED_STEP) |
                               (message_header == CMD_API_VERSION);
  assign header_strobe = word_strobe & ~awaiting_more_words;
  assign move_strobe   = word_strobe & (message_header == CMD_COORDINATED_STEP);

  // Timer sees the slot it is working on
  assign move_duration      = duration_buf[moveind];
  assign increment          = increment_buf[moveind];
  assign incrementincrement = incinc_buf[moveind];
  assign dir                = dir_r[moveind];

  // A slot is free when its toggle bits agree
  assign buffer_dtr = |(~(stepready ^ stepfinished));

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_received_r    <= '0;
      enable             <= 1'b0;
      microsteps         <= RST_MICROSTEPS;
      current            <= RST_CURRENT;
      clock_divisor      <= RST_CLOCK_DIVISOR;
      word_send_data     <= '0;
      message_header     <= '0;
      message_word_count <= '0;
      writemoveind       <= '0;
      stepready          <= '0;
      dir_r              <= '0;
    end else begin
      word_received_r <= {word_received_r[0], word_received};
      if (word_strobe) begin
        // Reply is zero unless a command loads one
        word_send_data <= '0;
        if (!awaiting_more_words) begin
          message_header     <= hdr.move.cmd;
          message_word_count <= 2'd1;
          case (hdr.move.cmd)
            CMD_COORDINATED_STEP: dir_r[writemoveind] <= hdr.move.dir;
            CMD_MOTOR_ENABLE:     enable <= hdr.enable.en;
            CMD_CLK_DIVISOR:      clock_divisor <= hdr.divisor.div;
            CMD_MOTORCONFIG: begin
              current    <= hdr.motor_cfg.current;
              microsteps <= hdr.motor_cfg.microsteps;
            end
            // Version bytes go out during the next word
            CMD_API_VERSION: begin
              word_send_data <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: ;
          endcase
        end else if (message_header == CMD_COORDINATED_STEP) begin
          message_word_count <= message_word_count + 2'd1;
          case (message_word_count)
            // Encoder snapshot rides out with the last data word
            2'd2: word_send_data <= encoder_store;
            2'd3: begin
              // Hand the slot to the timer and move on
              stepready[writemoveind] <= ~stepready[writemoveind];
              writemoveind            <= writemoveind + 1'b1;
              message_header          <= '0;
              message_word_count      <= '0;
            end
            default: ;
          endcase
        end else begin
          // Trailing word of a version query
          message_header     <= '0;
          message_word_count <= '0;
        end
      end
    end
  end

  // Snapshot and move words
  always_ff @(posedge CLK) begin
    if (header_strobe && hdr.move.cmd == CMD_COORDINATED_STEP) begin
      encoder_store <= encoder_count;
    end
    if (move_strobe) begin
      case (message_word_count)
        2'd1: duration_buf[writemoveind]  <= word_data_received;
        2'd2: increment_buf[writemoveind] <= word_data_received;
        2'd3: incinc_buf[writemoveind]    <= word_data_received;
        default: ;
      endcase
    end
  end

endmodule

// ==== src/spi_word.sv ====
`timescale 1ns/1ps

module spi_word import stepper_pkg::*; (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 SCK,
  input  logic                 CS,
  input  logic                 COPI,
  input  logic [WORD_BITS-1:0] word_send_data,
  output logic                 CIPO,
  output logic                 word_received,
  output logic [WORD_BITS-1:0] word_data_received
);

  // Two sync stages, plus a history stage for edge detect
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_active;
  logic last_bit;

  // Bits taken so far in the current word
  logic [$clog2(WORD_BITS)-1:0] bit_count;
  logic [WORD_BITS-1:0]         shift_in;
  logic [WORD_BITS-1:0]         shift_out;

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign cs_fall   = ~cs_q[1] & cs_q[2];
  assign cs_active = ~cs_q[1];
  assign last_bit  = bit_count == ($clog2(WORD_BITS))'(WORD_BITS - 1);

  // MSB of the reply always sits on the pin
  assign CIPO = shift_out[WORD_BITS-1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= '0;
      // CS idles high, so no false start after reset
      cs_q   <= '1;
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], SCK};
      cs_q   <= {cs_q[1:0], CS};
      copi_q <= {copi_q[0], COPI};
    end
  end

  // Word framing and the reply shifter
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count     <= '0;
      word_received <= 1'b0;
      shift_out     <= '0;
    end else begin
      word_received <= 1'b0;
      // CS high drops any partial word
      if (!cs_active || cs_fall) begin
        bit_count <= '0;
      end else if (sck_rise) begin
        bit_count     <= bit_count + 1'b1;
        word_received <= last_bit;
      end
      // Reply latched as the word opens, next bit out on falling SCK
      if (cs_fall) begin
        shift_out <= word_send_data;
      end else if (cs_active && sck_fall) begin
        shift_out <= {shift_out[WORD_BITS-2:0], 1'b0};
      end
    end
  end

  // Incoming data, MSB first
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      shift_in <= {shift_in[WORD_BITS-2:0], copi_q[1]};
      if (last_bit) begin
        word_data_received <= {shift_in[WORD_BITS-2:0], copi_q[1]};
      end
    end
  end

endmodule

// ==== src/stepper_pkg.sv ====
package stepper_pkg;

  // SPI word width, one full command or data word
  localparam int WORD_BITS = 64;

  // Move buffer depth and slot index width
  localparam int MOVE_BUFFER_SIZE = 2;
  localparam int MOVE_BUFFER_BITS = 1;

  // Command codes, carried in the top byte of a header word
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE     = 8'h0a;
  localparam logic [7:0] CMD_MOTORCONFIG      = 8'h10;
  localparam logic [7:0] CMD_CLK_DIVISOR      = 8'h20;
  localparam logic [7:0] CMD_API_VERSION      = 8'hfe;

  // API version reply bytes
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  // Configuration after reset
  localparam logic [2:0] RST_MICROSTEPS    = 3'd2;
  localparam logic [7:0] RST_CURRENT       = 8'd140;
  // 40 gives roughly 400 kHz ticks from a 16 MHz clock
  localparam logic [7:0] RST_CLOCK_DIVISOR = 8'd40;

  // Header word, seen through one view per command
  typedef union packed {
    struct packed {
      logic [7:0]  cmd;
      logic [54:0] rsvd;
      logic        dir;
    } move;
    struct packed {
      logic [7:0]  cmd;
      logic [54:0] rsvd;
      logic        en;
    } enable;
    struct packed {
      logic [7:0]  cmd;
      logic [47:0] rsvd;
      logic [7:0]  div;
    } divisor;
    struct packed {
      logic [7:0]  cmd;
      logic [39:0] rsvd_hi;
      logic [7:0]  current;
      logic [4:0]  rsvd_lo;
      logic [2:0]  microsteps;
    } motor_cfg;
    logic [63:0] raw;
  } cmd_word_u;

endpackage
